/* build.f */
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch.sv
design/decode.sv
design/regfile.sv
design/execute.sv
design/openmips.sv
tb/tb_checker.sv
tb/tb_top.sv

/* design/cpu_isa_pkg.sv */
// MIPS subset encodings
package cpu_isa_pkg;

    localparam int INST_W     = 32;
    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;

    // field widths inside an instruction word
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;

    // primary opcode in inst[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00,  // r-type, decoded by funct
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL in inst[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_SRA = 6'h03,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27
    } funct_e;

    // operations of the execute stage
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,  // bubble, also the reset value
        ALU_AND = 4'd1,
        ALU_OR  = 4'd2,
        ALU_XOR = 4'd3,
        ALU_NOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_LUI = 4'd8
    } aluop_e;

endpackage

/* design/cpu_pipe_pkg.sv */
// Pipeline stage types
package cpu_pipe_pkg;

    localparam int ADDR_W  = 32;
    localparam int PC_STEP = 4;

    // IF/ID register
    typedef struct packed {
        logic [ADDR_W-1:0]              pc;
        logic [cpu_isa_pkg::INST_W-1:0] inst;
    } if_id_t;

    // regfile read ports
    typedef struct packed {
        logic                               re1;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0] raddr1;
        logic                               re2;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0] raddr2;
    } rd_req_t;

    // ID/EX register
    typedef struct packed {
        cpu_isa_pkg::aluop_e                aluop;
        logic [cpu_isa_pkg::REG_W-1:0]      opa;
        logic [cpu_isa_pkg::REG_W-1:0]      opb;
        logic [cpu_isa_pkg::SHAMT_W-1:0]    shamt;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0] waddr;
        logic                               we;
    } id_ex_t;

    // one register write, same shape for ex, mem and wb paths
    typedef struct packed {
        logic                               we;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0] waddr;
        logic [cpu_isa_pkg::REG_W-1:0]      wdata;
    } wr_t;

endpackage

/* design/decode.sv */
// Instruction decode stage
module decode (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  cpu_pipe_pkg::if_id_t           if_id_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]  rdata1_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]  rdata2_i,
    output cpu_pipe_pkg::rd_req_t          rd_req_o,
    output cpu_pipe_pkg::id_ex_t           id_ex_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // instruction fields
    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    shamt;
    logic [IMM_W-1:0]      imm;

    aluop_e                aluop;
    logic                  valid;     // supported encoding
    logic                  use_imm;   // opb from immediate
    logic                  is_shift;
    logic                  is_lui;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
    id_ex_t                id_ex_d;

    assign opcode = opcode_e'(if_id_i.inst[31:26]);
    assign rs     = if_id_i.inst[25:21];
    assign rt     = if_id_i.inst[20:16];
    assign rd     = if_id_i.inst[15:11];
    assign shamt  = if_id_i.inst[10:6];
    assign funct  = funct_e'(if_id_i.inst[5:0]);
    assign imm    = if_id_i.inst[15:0];

    function automatic aluop_e funct_to_aluop(input funct_e fn);
        case (fn)
            FN_AND:  return ALU_AND;
            FN_OR:   return ALU_OR;
            FN_XOR:  return ALU_XOR;
            FN_NOR:  return ALU_NOR;
            FN_SLL:  return ALU_SLL;
            FN_SRL:  return ALU_SRL;
            FN_SRA:  return ALU_SRA;
            default: return ALU_NOP;  // unsupported funct
        endcase
    endfunction

    always_comb begin
        aluop = ALU_NOP;
        waddr = rt;  // i-type destination
        case (opcode)
            OP_SPECIAL: begin
                aluop = funct_to_aluop(funct);
                waddr = rd;
            end
            OP_ORI:  aluop = ALU_OR;
            OP_ANDI: aluop = ALU_AND;
            OP_XORI: aluop = ALU_XOR;
            OP_LUI:  aluop = ALU_LUI;
            default: aluop = ALU_NOP;
        endcase
    end

    assign valid    = (aluop != ALU_NOP);
    assign use_imm  = (opcode != OP_SPECIAL);
    assign is_shift = aluop inside {ALU_SLL, ALU_SRL, ALU_SRA};
    assign is_lui   = (aluop == ALU_LUI);
    assign we       = valid && (waddr != '0);

    // shifts and lui have no rs operand
    assign rd_req_o.re1    = valid && !is_shift && !is_lui;
    assign rd_req_o.raddr1 = rs;
    assign rd_req_o.re2    = valid && !use_imm;
    assign rd_req_o.raddr2 = rt;

    always_comb begin
        id_ex_d.aluop = we ? aluop : ALU_NOP;
        id_ex_d.opa   = rdata1_i;  // reads 0 when port is idle
        if (use_imm) begin
            id_ex_d.opb = {{(REG_W-IMM_W){1'b0}}, imm};
        end else begin
            id_ex_d.opb = rdata2_i;
        end
        id_ex_d.shamt = shamt;
        id_ex_d.waddr = waddr;
        id_ex_d.we    = we;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;  // bubble
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* design/execute.sv */
// Execute, memory and write-back stages
module execute (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  cpu_pipe_pkg::id_ex_t id_ex_i,
    output cpu_pipe_pkg::wr_t    ex_fwd_o,
    output cpu_pipe_pkg::wr_t    mem_fwd_o,
    output cpu_pipe_pkg::wr_t    wb_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [REG_W-1:0] alu_res;
    wr_t              ex_mem_q;
    wr_t              mem_wb_q;

    always_comb begin
        case (id_ex_i.aluop)
            ALU_AND: alu_res = id_ex_i.opa & id_ex_i.opb;
            ALU_OR:  alu_res = id_ex_i.opa | id_ex_i.opb;
            ALU_XOR: alu_res = id_ex_i.opa ^ id_ex_i.opb;
            ALU_NOR: alu_res = ~(id_ex_i.opa | id_ex_i.opb);
            ALU_SLL: alu_res = id_ex_i.opb << id_ex_i.shamt;
            ALU_SRL: alu_res = id_ex_i.opb >> id_ex_i.shamt;
            ALU_SRA: alu_res = $signed(id_ex_i.opb) >>> id_ex_i.shamt;  // sign fill
            ALU_LUI: alu_res = {id_ex_i.opb[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    // combinational result, forwarded to decode
    assign ex_fwd_o = '{we: id_ex_i.we, waddr: id_ex_i.waddr, wdata: alu_res};

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_fwd_o;
        end
    end

    // no data memory, the mem stage passes the result on
    assign mem_fwd_o = ex_mem_q;

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= mem_fwd_o;
        end
    end

    assign wb_o = mem_wb_q;  // regfile write port

endmodule

/* design/fetch.sv */
// Instruction fetch stage
module fetch (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [cpu_isa_pkg::INST_W-1:0]  rom_data_i,
    output logic                            rom_ce_o,
    output logic [cpu_pipe_pkg::ADDR_W-1:0] rom_addr_o,
    output cpu_pipe_pkg::if_id_t            if_id_o
);
    import cpu_pipe_pkg::*;

    logic [ADDR_W-1:0] pc;

    // rom enable comes up one edge after reset release
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (rom_ce_o) begin
            pc <= pc + ADDR_W'(PC_STEP);
        end else begin
            pc <= '0;  // held at 0 until enabled
        end
    end

    assign rom_addr_o = pc;

    // zero word while disabled, decodes as a bubble
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_o <= '0;
        end else begin
            if_id_o <= '{pc: pc, inst: (rom_ce_o ? rom_data_i : '0)};
        end
    end

endmodule

/* design/openmips.sv */
// Five stage MIPS core
module openmips (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [cpu_isa_pkg::INST_W-1:0]  rom_data_i,  // instruction word from rom
    output logic                            rom_ce_o,
    output logic [cpu_pipe_pkg::ADDR_W-1:0] rom_addr_o,
    output cpu_pipe_pkg::wr_t               wb_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    if_id_t           if_id;
    rd_req_t          rd_req;
    logic [REG_W-1:0] rdata1;
    logic [REG_W-1:0] rdata2;
    id_ex_t           id_ex;
    wr_t              ex_fwd;   // forwarding paths
    wr_t              mem_fwd;

    fetch fetch_0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .if_id_o    (if_id)
    );

    decode decode_0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .if_id_i  (if_id),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .rd_req_o (rd_req),
        .id_ex_o  (id_ex)
    );

    regfile regfile_0 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_req_i  (rd_req),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .wb_i      (wb_o),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    execute execute_0 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .id_ex_i   (id_ex),
        .ex_fwd_o  (ex_fwd),
        .mem_fwd_o (mem_fwd),
        .wb_o      (wb_o)
    );

endmodule

/* design/regfile.sv */
// Register file with bypass
module regfile (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  cpu_pipe_pkg::rd_req_t         rd_req_i,
    input  cpu_pipe_pkg::wr_t             ex_fwd_i,
    input  cpu_pipe_pkg::wr_t             mem_fwd_i,
    input  cpu_pipe_pkg::wr_t             wb_i,
    output logic [cpu_isa_pkg::REG_W-1:0] rdata1_o,
    output logic [cpu_isa_pkg::REG_W-1:0] rdata2_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [REG_W-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.waddr != '0)) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // youngest pending write wins, then the array
    function automatic logic [REG_W-1:0] read_port(
        input logic                  re,
        input logic [REG_ADDR_W-1:0] addr,
        input wr_t                   ex_w,
        input wr_t                   mem_w,
        input wr_t                   wb_w
    );
        logic [REG_W-1:0] data;
        if (!re || (addr == '0)) begin
            data = '0;
        end else if (ex_w.we && (ex_w.waddr == addr)) begin
            data = ex_w.wdata;
        end else if (mem_w.we && (mem_w.waddr == addr)) begin
            data = mem_w.wdata;
        end else if (wb_w.we && (wb_w.waddr == addr)) begin
            data = wb_w.wdata;  // write-through, same cycle
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(rd_req_i.re1, rd_req_i.raddr1, ex_fwd_i, mem_fwd_i, wb_i);
        rdata2_o = read_port(rd_req_i.re2, rd_req_i.raddr2, ex_fwd_i, mem_fwd_i, wb_i);
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_top
log=sim.log

echo "building ${top}"
verilator --binary --timing --timescale 1ns/1ps --top-module "${top}" \
    -f build.f -o "sim_${top}" > build.log 2>&1
build_status=$?
if [ ${build_status} -ne 0 ]; then
    cat build.log
    echo "error: verilator build failed with status ${build_status}"
    exit 1
fi

echo "running ${top}"
"./obj_dir/sim_${top}" > "${log}" 2>&1
run_status=$?
cat "${log}"
if [ ${run_status} -ne 0 ]; then
    echo "error: simulation exited with status ${run_status}"
    exit 1
fi

if grep -qx "Finished with no errors" "${log}"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail, see ${log}"
exit 1

/* tb/tb_checker.sv */
// Pipeline write-back checker
module tb_checker (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            rom_ce_i,
    input  logic [cpu_pipe_pkg::ADDR_W-1:0] rom_addr_i,
    input  logic [cpu_isa_pkg::INST_W-1:0]  rom_data_i,
    input  cpu_pipe_pkg::wr_t               wb_i,
    output int                              err_cnt_o,
    output int                              wb_seen_o,
    output int                              wb_expected_o,
    output int                              fetch_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [REG_W-1:0]  model [2**REG_ADDR_W];  // architectural state of the reference
    wr_t               exp_q [$];              // writes still in flight
    wr_t               ref_wr;
    wr_t               exp_wr;
    logic [ADDR_W-1:0] next_addr;
    int                err_cnt = 0;
    int                wb_seen = 0;
    int                wb_expected = 0;
    int                fetch_cnt = 0;

    assign err_cnt_o     = err_cnt;
    assign wb_seen_o     = wb_seen;
    assign wb_expected_o = wb_expected;
    assign fetch_cnt_o   = fetch_cnt;

    // one instruction on the model, returns the write it should cause
    function automatic wr_t ref_exec(input logic [INST_W-1:0] inst);
        logic [REG_ADDR_W-1:0]   rs;
        logic [REG_ADDR_W-1:0]   rt;
        logic [REG_ADDR_W-1:0]   rd;
        logic [4:0]              sa;
        logic [REG_W-1:0]        zimm;
        logic signed [REG_W-1:0] srt;
        wr_t                     w;
        rs   = inst[25:21];
        rt   = inst[20:16];
        rd   = inst[15:11];
        sa   = inst[10:6];
        zimm = {16'h0000, inst[15:0]};
        srt  = model[rt];
        w    = '{we: 1'b1, waddr: rt, wdata: '0};
        case (inst[31:26])
            OP_ORI:  w.wdata = model[rs] | zimm;
            OP_ANDI: w.wdata = model[rs] & zimm;
            OP_XORI: w.wdata = model[rs] ^ zimm;
            OP_LUI:  w.wdata = {inst[15:0], 16'h0000};
            OP_SPECIAL: begin
                w.waddr = rd;
                case (inst[5:0])
                    FN_AND:  w.wdata = model[rs] & model[rt];
                    FN_OR:   w.wdata = model[rs] | model[rt];
                    FN_XOR:  w.wdata = model[rs] ^ model[rt];
                    FN_NOR:  w.wdata = ~(model[rs] | model[rt]);
                    FN_SLL:  w.wdata = model[rt] << sa;
                    FN_SRL:  w.wdata = model[rt] >> sa;
                    FN_SRA:  w.wdata = srt >>> sa;  // ones in from the top when negative
                    default: w.we = 1'b0;
                endcase
            end
            default: w.we = 1'b0;
        endcase
        if (w.waddr == '0) begin
            w.we = 1'b0;  // r0 never written
        end
        return w;
    endfunction

    task automatic compare_write();
        if (exp_q.size() == 0) begin
            $display("time %0t: write-back to r%0d arrived with no instruction expecting one",
                     $time, wb_i.waddr);
            err_cnt++;
        end else begin
            exp_wr = exp_q.pop_front();
            wb_seen++;
            if (wb_i.waddr !== exp_wr.waddr || wb_i.wdata !== exp_wr.wdata) begin
                $display("FAIL at %0t: write-back %0d expected r%0d=%08h, got r%0d=%08h",
                         $time, wb_seen, exp_wr.waddr, exp_wr.wdata, wb_i.waddr, wb_i.wdata);
                err_cnt++;
            end
        end
    endtask

    task automatic record_fetch();
        if (rom_addr_i !== next_addr) begin
            $display("FAIL at %0t: fetch address expected %08h, got %08h",
                     $time, next_addr, rom_addr_i);
            err_cnt++;
        end
        next_addr = rom_addr_i + ADDR_W'(PC_STEP);
        fetch_cnt++;
        ref_wr = ref_exec(rom_data_i);
        if (ref_wr.we) begin
            model[ref_wr.waddr] = ref_wr.wdata;
            exp_q.push_back(ref_wr);
            wb_expected++;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n_i) begin
            if (rom_ce_i || wb_i.we) begin
                $display("FAIL at %0t: in reset rom_ce=%b wb.we=%b, both expected 0",
                         $time, rom_ce_i, wb_i.we);
                err_cnt++;
            end
            foreach (model[i]) begin
                model[i] = '0;
            end
            exp_q.delete();
            next_addr = '0;  // first fetch after release
        end else begin
            if (wb_i.we) begin
                compare_write();
            end
            if (rom_ce_i) begin
                record_fetch();
            end
        end
    end

endmodule

/* tb/tb_top.sv */
// Pipeline testbench top
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int HALF_PERIOD    = 50;
    localparam int RESET_CYCLES   = 16;
    localparam int N_RANDOM       = 200;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DRAIN_FETCHES  = 4;  // fetch to write-back latency

    logic              clk = 1'b0;
    logic              arst_n_i;
    logic [INST_W-1:0] rom_data_i;
    logic              rom_ce_o;
    logic [ADDR_W-1:0] rom_addr_o;
    wr_t               wb_o;

    logic [INST_W-1:0] rom [256];
    int                prog_len = 0;
    logic [31:0]       rng_state;
    int                err_cnt;
    int                wb_seen;
    int                wb_expected;
    int                fetch_cnt;
    int                cycles;
    int                timeout_err;

    openmips openmips_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .wb_o       (wb_o)
    );

    tb_checker check_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .rom_ce_i      (rom_ce_o),
        .rom_addr_i    (rom_addr_o),
        .rom_data_i    (rom_data_i),
        .wb_i          (wb_o),
        .err_cnt_o     (err_cnt),
        .wb_seen_o     (wb_seen),
        .wb_expected_o (wb_expected),
        .fetch_cnt_o   (fetch_cnt)
    );

    initial begin
        forever #HALF_PERIOD clk = ~clk;
    end

    // rom lookup returns zero past the program end
    always @(negedge clk) begin
        if ((rom_addr_o >> 2) < prog_len) begin
            rom_data_i <= rom[rom_addr_o[9:2]];
        end else begin
            rom_data_i <= '0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    // force a random word off the supported opcodes and functs
    function automatic logic [31:0] unsupported_word(input logic [31:0] w);
        logic [31:0] u;
        u = w;
        if (u[31:26] inside {6'h0c, 6'h0d, 6'h0e, 6'h0f}) begin
            u[31:26] = 6'h23;  // lw
        end
        if (u[31:26] == 6'h00 && u[5:0] inside {6'h00, 6'h02, 6'h03, [6'h24:6'h27]}) begin
            u[5:0] = 6'h20;  // add
        end
        return u;
    endfunction

    task automatic append_inst(input logic [31:0] inst);
        rom[8'(prog_len)] = inst;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] f;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        int          kind;
        append_inst(i_type(OP_ORI,  5'd0, 5'd1, 16'h1234));
        append_inst(i_type(OP_ORI,  5'd0, 5'd2, 16'hffff));  // zero extended
        append_inst(i_type(OP_LUI,  5'd0, 5'd3, 16'h8765));
        append_inst(i_type(OP_ORI,  5'd3, 5'd3, 16'h4321));  // r3 one back
        append_inst(i_type(OP_ANDI, 5'd3, 5'd4, 16'hff0f));
        append_inst(i_type(OP_XORI, 5'd2, 5'd5, 16'haaaa));
        append_inst(r_type(5'd1, 5'd3, 5'd6, 5'd0, FN_AND));
        append_inst(r_type(5'd6, 5'd2, 5'd7, 5'd0, FN_OR));
        append_inst(r_type(5'd3, 5'd7, 5'd8, 5'd0, FN_XOR));
        append_inst(r_type(5'd1, 5'd8, 5'd9, 5'd0, FN_NOR));
        append_inst(r_type(5'd0, 5'd3, 5'd10, 5'd4, FN_SLL));
        append_inst(r_type(5'd0, 5'd3, 5'd11, 5'd8, FN_SRL));
        append_inst(r_type(5'd0, 5'd3, 5'd12, 5'd12, FN_SRA));  // negative operand
        append_inst(r_type(5'd0, 5'd12, 5'd13, 5'd31, FN_SRA));
        // dependency chain at distances 1, 2 and 3
        append_inst(i_type(OP_ORI, 5'd0, 5'd20, 16'h00ff));
        append_inst(i_type(OP_ORI, 5'd0, 5'd21, 16'h0f00));
        append_inst(i_type(OP_ORI, 5'd0, 5'd22, 16'h3000));
        append_inst(r_type(5'd20, 5'd0, 5'd23, 5'd0, FN_OR));
        append_inst(r_type(5'd21, 5'd23, 5'd24, 5'd0, FN_OR));
        append_inst(r_type(5'd22, 5'd24, 5'd25, 5'd0, FN_XOR));
        append_inst(r_type(5'd25, 5'd23, 5'd26, 5'd0, FN_NOR));
        append_inst(r_type(5'd26, 5'd25, 5'd27, 5'd0, FN_AND));
        // none of these may reach write-back
        append_inst(i_type(OP_ORI, 5'd1, 5'd0, 16'h5555));
        append_inst(r_type(5'd1, 5'd2, 5'd0, 5'd0, FN_OR));
        append_inst(32'h2021_0005);  // addi
        append_inst(32'h0022_0820);  // add
        append_inst(r_type(5'd0, 5'd1, 5'd28, 5'd0, FN_OR));  // r0 still reads 0
        rng_state = 32'd88465;
        for (int i = 0; i < N_RANDOM; i++) begin
            f    = next_rand();
            sa   = f[31:27];
            rs   = {2'b00, f[26:24]};  // r0..r7 for dense hazards
            rt   = {2'b00, f[23:21]};
            rd   = {2'b00, f[20:18]};
            kind = next_rand() % 32'd11;
            if (next_rand() % 32'd10 == 0) begin
                append_inst(unsupported_word(next_rand()));
            end else begin
                case (kind)
                    0:       append_inst(i_type(OP_ORI, rs, rt, f[15:0]));
                    1:       append_inst(i_type(OP_ANDI, rs, rt, f[15:0]));
                    2:       append_inst(i_type(OP_XORI, rs, rt, f[15:0]));
                    3:       append_inst(i_type(OP_LUI, 5'd0, rt, f[15:0]));
                    4:       append_inst(r_type(rs, rt, rd, 5'd0, FN_AND));
                    5:       append_inst(r_type(rs, rt, rd, 5'd0, FN_OR));
                    6:       append_inst(r_type(rs, rt, rd, 5'd0, FN_XOR));
                    7:       append_inst(r_type(rs, rt, rd, 5'd0, FN_NOR));
                    8:       append_inst(r_type(5'd0, rt, rd, sa, FN_SLL));
                    9:       append_inst(r_type(5'd0, rt, rd, sa, FN_SRL));
                    default: append_inst(r_type(5'd0, rt, rd, sa, FN_SRA));
                endcase
            end
        end
    endtask

    // last instruction has left the pipeline and every expected write arrived
    function automatic logic run_done();
        return (fetch_cnt >= prog_len + DRAIN_FETCHES) && (wb_seen == wb_expected);
    endfunction

    initial begin
        arst_n_i   = 1'b0;
        rom_data_i = '0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n_i = 1'b1;
        cycles   = 0;
        while (!run_done() && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        timeout_err = 0;
        if (!run_done()) begin
            $display("timeout: only %0d of %0d expected write-backs arrived in %0d cycles",
                     wb_seen, wb_expected, cycles);
            timeout_err = 1;
        end
        $display("errors: %0d, timeouts: %0d, write-backs checked: %0d of %0d, fetches: %0d",
                 err_cnt, timeout_err, wb_seen, wb_expected, fetch_cnt);
        if (err_cnt + timeout_err == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
